//--- periph_vectors.txt
# Columns: command, address, data, expected, mask (hex). W write, R read under mask,
# L read at most expected, P interrupt lines, D idle cycles, O outputs 8:0
# Register read back
W 4800 0000a5a0 00000000 00000000
R 4800 00000000 0000a5a0 ffffffff
W 4000 00000015 00000000 00000000
R 4000 00000000 00000015 ffffffff
O 0000 00000000 00000054 000001ff
W 4000 00000000 00000000 00000000
W 5000 20000064 00000000 00000000
R 5000 00000000 20000064 ffffffff
W 5000 00000000 00000000 00000000
W 1800 ffffffff 00000000 00000000
R 1800 00000000 00000000 ffffffff
# PIC mask and status
W 4800 00000000 00000000 00000000
P 0000 00000010 00000000 00000000
D 0000 00000002 00000000 00000000
R 4802 00000000 00000010 ffffffff
O 0000 00000000 00000000 000001ff
W 4800 00000010 00000000 00000000
O 0000 00000000 00000101 000001ff
P 0000 00000000 00000000 00000000
W 4802 00000000 00000000 00000000
R 4802 00000000 00000000 ffffffff
O 0000 00000000 00000000 000001ff
# One-shot timer, TP 20, IE set
W 5001 00000000 00000000 00000000
W 5000 a0000014 00000000 00000000
D 0000 00000028 00000000 00000000
R 5001 00000000 00000014 ffffffff
R 5000 00000000 b0000014 ffffffff
O 0000 00000000 00000002 000001ff
W 5000 a0000014 00000000 00000000
O 0000 00000000 00000000 000001ff
R 5000 00000000 a0000014 ffffffff
# Restart timer, TP 5
W 5000 00000000 00000000 00000000
W 5001 00000000 00000000 00000000
W 5000 40000005 00000000 00000000
D 0000 0000000a 00000000 00000000
R 5000 00000000 10000000 10000000
L 5001 00000000 00000005 ffffffff
W 5000 00000000 00000000 00000000
# Power management and wakeup
W 4000 00000023 00000000 00000000
O 0000 00000000 000000cc 000001ff
R 4000 00000000 00000023 ffffffff
P 0000 00000010 00000000 00000000
D 0000 00000003 00000000 00000000
O 0000 00000000 0000010d 000001ff
R 4000 00000000 00000003 ffffffff
P 0000 00000000 00000000 00000000
W 4802 00000000 00000000 00000000
O 0000 00000000 0000000c 000001ff

//--- verilog.f
or1200_pkg.sv
spr_bus_if.sv
or1200_spr_access.sv
or1200_pic.sv
or1200_tt.sv
or1200_pm.sv
or1200_periph_top.sv
tb_or1200_checker.sv
tb_or1200_periph.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_or1200_periph
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Output goes to the terminal; status comes from the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_or1200_periph.sv
// Testbench top with clock, reset, vector file reader, SPR access driver and final report
`timescale 1ns/1ps
`default_nettype none

module tb_or1200_periph;
	import or1200_pkg::*;

	// Longest wait for an acknowledge, in cycles
	localparam int ACK_TIMEOUT = 20;

	// DUT inputs
	logic                clk;
	logic                reset;
	logic [PIC_INTS-1:0] pic_ints;
	logic                dbg_stb;
	logic                dbg_we;
	logic [SPR_AW-1:0]   dbg_adr;
	logic [SPR_DW-1:0]   dbg_dat_wr;
	// DUT outputs
	logic [SPR_DW-1:0]   dbg_dat_rd;
	logic                dbg_ack;
	logic                intr;
	logic                tick;
	logic [PM_SDF_W-1:0] pm_clksd;
	logic                pm_cpu_gate;
	logic                pm_lvolt;
	logic                pm_wakeup;

	// Checker control
	logic                rd_chk;
	logic                le_chk;
	logic                out_chk;
	logic [SPR_DW-1:0]   exp_val;
	logic [SPR_DW-1:0]   exp_mask;
	logic [31:0]         mismatches;

	int                  timeouts;
	int                  other_errs;
	int                  fd;
	int                  n;
	logic [63:0]         token;
	logic [8*256-1:0]    rest;
	logic [31:0]         f_adr;
	logic [31:0]         f_dat;
	logic [31:0]         f_exp;
	logic [31:0]         f_msk;

	always #5 clk = ~clk;

	or1200_periph_top u_or1200_periph_top (
		.clk_i         (clk),
		.reset_i       (reset),
		.pic_ints_i    (pic_ints),
		.dbg_stb_i     (dbg_stb),
		.dbg_we_i      (dbg_we),
		.dbg_adr_i     (dbg_adr),
		.dbg_dat_i     (dbg_dat_wr),
		.dbg_dat_o     (dbg_dat_rd),
		.dbg_ack_o     (dbg_ack),
		.intr_o        (intr),
		.tick_o        (tick),
		.pm_clksd_o    (pm_clksd),
		.pm_cpu_gate_o (pm_cpu_gate),
		.pm_lvolt_o    (pm_lvolt),
		.pm_wakeup_o   (pm_wakeup)
	);

	tb_or1200_checker u_checker (
		.clk_i         (clk),
		.dbg_stb_i     (dbg_stb),
		.dbg_ack_i     (dbg_ack),
		.dbg_dat_i     (dbg_dat_rd),
		.intr_i        (intr),
		.tick_i        (tick),
		.pm_clksd_i    (pm_clksd),
		.pm_cpu_gate_i (pm_cpu_gate),
		.pm_lvolt_i    (pm_lvolt),
		.pm_wakeup_i   (pm_wakeup),
		.rd_chk_i      (rd_chk),
		.le_chk_i      (le_chk),
		.out_chk_i     (out_chk),
		.exp_i         (exp_val),
		.mask_i        (exp_mask),
		.err_cnt_o     (mismatches)
	);

	//////////////////////////////////////////////////////////////////////
	// Driver tasks
	//////////////////////////////////////////////////////////////////////

	// 1 ns past the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// One strobe, held until ack, then one idle cycle
	task automatic spr_access(input logic we, input logic [SPR_AW-1:0] adr,
		input logic [SPR_DW-1:0] dat);
		int   waited;
		logic acked;
		waited     = 0;
		acked      = 1'b0;
		dbg_stb    = 1'b1;
		dbg_we     = we;
		dbg_adr    = adr;
		dbg_dat_wr = dat;
		// Ack looked at mid-cycle
		while (!acked && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (dbg_ack)
				acked = 1'b1;
		end
		if (!acked) begin
			timeouts++;
			$display("no acknowledge within %0d cycles for the access to address %h",
				ACK_TIMEOUT, adr);
		end
		next_cycle();
		dbg_stb = 1'b0;
		dbg_we  = 1'b0;
		rd_chk  = 1'b0;
		le_chk  = 1'b0;
		next_cycle();
	endtask

	// Read with exact compare, or upper bound when le is set
	task automatic read_check(input logic [31:0] adr, input logic [31:0] expv,
		input logic [31:0] maskv, input logic le);
		exp_val  = expv;
		exp_mask = maskv;
		rd_chk   = !le;
		le_chk   = le;
		spr_access(1'b0, adr[SPR_AW-1:0], '0);
	endtask

	// One cycle of output compare
	task automatic check_outputs(input logic [31:0] expv, input logic [31:0] maskv);
		exp_val  = expv;
		exp_mask = maskv;
		out_chk  = 1'b1;
		next_cycle();
		out_chk  = 1'b0;
	endtask

	task automatic run_command(input logic [7:0] cmd, input logic [31:0] a,
		input logic [31:0] d, input logic [31:0] e, input logic [31:0] m);
		case (cmd)
			"W": spr_access(1'b1, a[SPR_AW-1:0], d);
			"R": read_check(a, e, m, 1'b0);
			"L": read_check(a, e, m, 1'b1);
			"P": begin
				pic_ints = d[PIC_INTS-1:0];
				next_cycle();
			end
			"D": repeat (d) next_cycle();
			"O": check_outputs(e, m);
			default: begin
				other_errs++;
				$display("unknown command %c in the vector file", cmd);
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		pic_ints   = '0;
		dbg_stb    = 1'b0;
		dbg_we     = 1'b0;
		dbg_adr    = '0;
		dbg_dat_wr = '0;
		rd_chk     = 1'b0;
		le_chk     = 1'b0;
		out_chk    = 1'b0;
		exp_val    = '0;
		exp_mask   = '0;
		timeouts   = 0;
		other_errs = 0;
		// Five cycles of reset
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		next_cycle();

		fd = $fopen("periph_vectors.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("cannot open the vector file periph_vectors.txt");
		end else begin
			while ($fscanf(fd, "%s", token) == 1) begin
				if (token == "#") begin
					// Rest of a comment line
					n = $fgets(rest, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %h", f_adr, f_dat, f_exp, f_msk);
					if (n != 4) begin
						other_errs++;
						$display("vector line for command %c is missing fields", token[7:0]);
					end else begin
						run_command(token[7:0], f_adr, f_dat, f_exp, f_msk);
					end
				end
			end
			$fclose(fd);
		end

		$display("errors: %0d mismatches, %0d timeouts, %0d other failures",
			mismatches, timeouts, other_errs);
		if (mismatches == 0 && timeouts == 0 && other_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_or1200_checker.sv
// Checker for read data, level outputs and ack latency, with error count
`timescale 1ns/1ps
`default_nettype none

module tb_or1200_checker (
	input  logic                            clk_i,
	// Access port as seen on the DUT pins
	input  logic                            dbg_stb_i,
	input  logic                            dbg_ack_i,
	input  logic [or1200_pkg::SPR_DW-1:0]   dbg_dat_i,
	// Level outputs
	input  logic                            intr_i,
	input  logic                            tick_i,
	input  logic [or1200_pkg::PM_SDF_W-1:0] pm_clksd_i,
	input  logic                            pm_cpu_gate_i,
	input  logic                            pm_lvolt_i,
	input  logic                            pm_wakeup_i,
	// Compare requests from the driver
	input  logic                            rd_chk_i,
	input  logic                            le_chk_i,
	input  logic                            out_chk_i,
	input  logic [or1200_pkg::SPR_DW-1:0]   exp_i,
	input  logic [or1200_pkg::SPR_DW-1:0]   mask_i,
	output logic [31:0]                     err_cnt_o
);
	import or1200_pkg::*;

	// Strobe sampled at edge 0, ack sampled after edge 1
	localparam int ACK_LATENCY = 2;

	logic [8:0]        out_pack;
	logic [SPR_DW-1:0] out_ext;
	logic              busy = 1'b0;
	int                cnt = 0;
	int                errs = 0;

	// 8 wakeup, 7 lvolt, 6 cpu gate, 5:2 clksd, 1 tick, 0 intr
	assign out_pack  = {pm_wakeup_i, pm_lvolt_i, pm_cpu_gate_i, pm_clksd_i, tick_i, intr_i};
	assign out_ext   = {{(SPR_DW-9){1'b0}}, out_pack};
	assign err_cnt_o = errs;

	//////////////////////////////////////////////////////////////////////
	// Compares, all at the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_i) begin
		if (dbg_ack_i && rd_chk_i && ((dbg_dat_i & mask_i) !== (exp_i & mask_i))) begin
			errs++;
			$display("mismatch at time %0t: read data %h, expected %h under mask %h",
				$time, dbg_dat_i, exp_i, mask_i);
		end
		// Upper bound on the masked read value
		if (dbg_ack_i && le_chk_i && ((dbg_dat_i & mask_i) > exp_i)) begin
			errs++;
			$display("mismatch at time %0t: read data %h, expected at most %h",
				$time, dbg_dat_i, exp_i);
		end
		if (out_chk_i && ((out_ext & mask_i) !== (exp_i & mask_i))) begin
			errs++;
			$display("mismatch at time %0t: outputs %h, expected %h under mask %h",
				$time, out_pack, exp_i[8:0], mask_i[8:0]);
		end

		// Ack latency per access
		if (busy) begin
			cnt++;
			if (dbg_ack_i) begin
				if (cnt != ACK_LATENCY) begin
					errs++;
					$display("mismatch at time %0t: ack after %0d cycles, expected %0d",
						$time, cnt, ACK_LATENCY);
				end
				busy = 1'b0;
			end else if (cnt >= 20) begin
				busy = 1'b0;
			end
		end else if (dbg_ack_i) begin
			errs++;
			$display("acknowledge seen with no strobe pending at time %0t", $time);
		end else if (dbg_stb_i) begin
			busy = 1'b1;
			cnt  = 0;
		end
	end

endmodule

`default_nettype wire

//--- or1200_periph_top.sv
// Top level with SPR access port, PIC, tick timer and power management
`timescale 1ns/1ps
`default_nettype none

module or1200_periph_top (
	input  logic                            clk_i,
	input  logic                            reset_i,
	// Interrupt lines
	input  logic [or1200_pkg::PIC_INTS-1:0] pic_ints_i,
	// External SPR access port
	input  logic                            dbg_stb_i,
	input  logic                            dbg_we_i,
	input  logic [or1200_pkg::SPR_AW-1:0]   dbg_adr_i,
	input  logic [or1200_pkg::SPR_DW-1:0]   dbg_dat_i,
	output logic [or1200_pkg::SPR_DW-1:0]   dbg_dat_o,
	output logic                            dbg_ack_o,
	// Interrupt and tick to the core
	output logic                            intr_o,
	output logic                            tick_o,
	// Power management
	output logic [or1200_pkg::PM_SDF_W-1:0] pm_clksd_o,
	output logic                            pm_cpu_gate_o,
	output logic                            pm_lvolt_o,
	output logic                            pm_wakeup_o
);

	// PIC to PM
	logic pic_wakeup;

	// One bus per SPR unit
	spr_bus_if spr_pic ();
	spr_bus_if spr_tt ();
	spr_bus_if spr_pm ();

	//////////////////////////////////////////////////////////////////////
	// Access unit
	//////////////////////////////////////////////////////////////////////

	or1200_spr_access u_spr_access (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.dbg_stb_i (dbg_stb_i),
		.dbg_we_i  (dbg_we_i),
		.dbg_adr_i (dbg_adr_i),
		.dbg_dat_i (dbg_dat_i),
		.dbg_dat_o (dbg_dat_o),
		.dbg_ack_o (dbg_ack_o),
		.spr_pic   (spr_pic.master),
		.spr_tt    (spr_tt.master),
		.spr_pm    (spr_pm.master)
	);

	//////////////////////////////////////////////////////////////////////
	// SPR units
	//////////////////////////////////////////////////////////////////////

	// Group 9
	or1200_pic u_pic (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.spr          (spr_pic.slave),
		.pic_ints_i   (pic_ints_i),
		.intr_o       (intr_o),
		.pic_wakeup_o (pic_wakeup)
	);

	// Group 10
	or1200_tt u_tt (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.spr     (spr_tt.slave),
		.tick_o  (tick_o)
	);

	// Group 8
	or1200_pm u_pm (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.spr           (spr_pm.slave),
		.pic_wakeup_i  (pic_wakeup),
		.pm_clksd_o    (pm_clksd_o),
		.pm_cpu_gate_o (pm_cpu_gate_o),
		.pm_lvolt_o    (pm_lvolt_o),
		.pm_wakeup_o   (pm_wakeup_o)
	);

endmodule

`default_nettype wire

//--- or1200_pm.sv
// Power management register with clock slowdown, CPU gate, low voltage and wakeup outputs
`timescale 1ns/1ps
`default_nettype none

module or1200_pm (
	input  logic                            clk_i,
	input  logic                            reset_i,
	spr_bus_if.slave                        spr,
	input  logic                            pic_wakeup_i,
	output logic [or1200_pkg::PM_SDF_W-1:0] pm_clksd_o,
	output logic                            pm_cpu_gate_o,
	output logic                            pm_lvolt_o,
	output logic                            pm_wakeup_o
);
	import or1200_pkg::*;

	// SDF, DME and SME only
	logic [PMR_SME:0] pmr;
	logic             pmr_wr;

	assign pmr_wr = spr.cs && spr.we && (spr.addr == PM_REG_MR);

	//////////////////////////////////////////////////////////////////////
	// PMR
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pmr <= '0;
		end else begin
			if (pmr_wr)
				pmr <= spr.wdat[PMR_SME:0];
			// Wakeup leaves doze and sleep, even over a write
			if (pic_wakeup_i) begin
				pmr[PMR_DME] <= 1'b0;
				pmr[PMR_SME] <= 1'b0;
			end
		end
	end

	// Control outputs straight from PMR
	assign pm_clksd_o    = pmr[PMR_SDF_LSB +: PM_SDF_W];
	assign pm_cpu_gate_o = pmr[PMR_DME] | pmr[PMR_SME];
	// Sleep also drops the core voltage
	assign pm_lvolt_o    = pmr[PMR_SME];
	assign pm_wakeup_o   = pic_wakeup_i;

	assign spr.rdat = (spr.addr == PM_REG_MR) ? {{(SPR_DW-PMR_SME-1){1'b0}}, pmr} : '0;

endmodule

`default_nettype wire

//--- or1200_tt.sv
// Tick timer with TTMR, TTCR counter and tick interrupt
`timescale 1ns/1ps
`default_nettype none

module or1200_tt (
	input  logic     clk_i,
	input  logic     reset_i,
	spr_bus_if.slave spr,
	output logic     tick_o
);
	import or1200_pkg::*;

	logic [SPR_DW-1:0]  ttmr;
	logic [SPR_DW-1:0]  ttcr;
	logic [TT_TP_W-1:0] tp;
	tt_mode_t           mode;
	logic               ttmr_wr;
	logic               ttcr_wr;
	logic               match;
	logic               match_q;
	logic               hit;

	assign ttmr_wr = spr.cs && spr.we && (spr.addr == TT_REG_MR);
	assign ttcr_wr = spr.cs && spr.we && (spr.addr == TT_REG_CR);

	assign tp   = ttmr[TTMR_TP_LSB +: TT_TP_W];
	assign mode = tt_mode_t'(ttmr[TTMR_M_MSB:TTMR_M_LSB]);

	// Low bits of the counter against the period
	assign match = (ttcr[TT_TP_W-1:0] == tp);

	// First cycle of a match, so a held one-shot does not refire
	assign hit = match && !match_q && (mode != TT_DISABLED);

	//////////////////////////////////////////////////////////////////////
	// Mode register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ttmr    <= '0;
			match_q <= 1'b0;
		end else begin
			match_q <= match;
			if (ttmr_wr)
				ttmr <= spr.wdat;
			// IP sticks until written back to 0
			if (hit)
				ttmr[TTMR_IP] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ttcr <= '0;
		end else if (ttcr_wr) begin
			// Written value beats counting
			ttcr <= spr.wdat;
		end else begin
			case (mode)
				TT_RESTART: ttcr <= match ? '0 : ttcr + 1'b1;
				// Stop at TP
				TT_ONESHOT: ttcr <= match ? ttcr : ttcr + 1'b1;
				TT_CONT:    ttcr <= ttcr + 1'b1;
				default:    ttcr <= ttcr;
			endcase
		end
	end

	assign tick_o = ttmr[TTMR_IP] & ttmr[TTMR_IE];

	always_comb begin
		case (spr.addr)
			TT_REG_MR: spr.rdat = ttmr;
			TT_REG_CR: spr.rdat = ttcr;
			default:   spr.rdat = '0;
		endcase
	end

	// One-shot counter stays at TP once reached
	a_oneshot_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		(mode == TT_ONESHOT && match && !ttcr_wr && !ttmr_wr) |=> (ttcr == $past(ttcr)));

endmodule

`default_nettype wire

//--- or1200_pic.sv
// Programmable interrupt controller with PICMR, PICSR, interrupt and wakeup outputs
`timescale 1ns/1ps
`default_nettype none

module or1200_pic (
	input  logic                            clk_i,
	input  logic                            reset_i,
	spr_bus_if.slave                        spr,
	input  logic [or1200_pkg::PIC_INTS-1:0] pic_ints_i,
	output logic                            intr_o,
	output logic                            pic_wakeup_o
);
	import or1200_pkg::*;

	logic [PIC_INTS-1:0] picmr;
	logic [PIC_INTS-1:0] picsr;
	logic                mr_wr;
	logic                sr_wr;
	logic                pending;

	assign mr_wr = spr.cs && spr.we && (spr.addr == PIC_REG_MR);
	assign sr_wr = spr.cs && spr.we && (spr.addr == PIC_REG_SR);

	//////////////////////////////////////////////////////////////////////
	// Mask and status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			picmr <= '0;
			picsr <= '0;
		end else begin
			if (mr_wr)
				picmr <= spr.wdat[PIC_INTS-1:0];
			// Active lines win over a write of 0
			if (sr_wr)
				picsr <= spr.wdat[PIC_INTS-1:0] | pic_ints_i;
			else
				picsr <= picsr | pic_ints_i;
		end
	end

	// Any unmasked pending bit
	assign pending      = |(picsr & picmr);
	assign intr_o       = pending;
	assign pic_wakeup_o = pending;

	// Read back, upper bits zero
	always_comb begin
		case (spr.addr)
			PIC_REG_MR: spr.rdat = {{(SPR_DW-PIC_INTS){1'b0}}, picmr};
			PIC_REG_SR: spr.rdat = {{(SPR_DW-PIC_INTS){1'b0}}, picsr};
			default:    spr.rdat = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- or1200_spr_access.sv
// External SPR access port with group decode, chip selects and read data return
`timescale 1ns/1ps
`default_nettype none

module or1200_spr_access (
	input  logic                          clk_i,
	input  logic                          reset_i,
	// External access port
	input  logic                          dbg_stb_i,
	input  logic                          dbg_we_i,
	input  logic [or1200_pkg::SPR_AW-1:0] dbg_adr_i,
	input  logic [or1200_pkg::SPR_DW-1:0] dbg_dat_i,
	output logic [or1200_pkg::SPR_DW-1:0] dbg_dat_o,
	output logic                          dbg_ack_o,
	// One connection per SPR unit
	spr_bus_if.master                     spr_pic,
	spr_bus_if.master                     spr_tt,
	spr_bus_if.master                     spr_pm
);
	import or1200_pkg::*;

	logic [SPR_GROUP_W-1:0] grp;
	logic                   start;
	logic                   req_q;
	logic                   we_q;
	logic [SPR_REG_W-1:0]   addr_q;
	logic [SPR_DW-1:0]      wdat_q;
	logic                   cs_pic_q;
	logic                   cs_tt_q;
	logic                   cs_pm_q;
	logic [SPR_DW-1:0]      rdat_sel;

	//////////////////////////////////////////////////////////////////////
	// Request phase
	//////////////////////////////////////////////////////////////////////

	assign grp = dbg_adr_i[SPR_GROUP_MSB:SPR_GROUP_LSB];

	// New strobe only when idle
	// Ack cycle blocks the strobe still held by the master
	assign start = dbg_stb_i && !req_q && !dbg_ack_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			req_q    <= 1'b0;
			we_q     <= 1'b0;
			cs_pic_q <= 1'b0;
			cs_tt_q  <= 1'b0;
			cs_pm_q  <= 1'b0;
		end else begin
			req_q    <= start;
			we_q     <= start && dbg_we_i;
			// At most one select, none for unmapped groups
			cs_pic_q <= start && (grp == GROUP_PIC);
			cs_tt_q  <= start && (grp == GROUP_TT);
			cs_pm_q  <= start && (grp == GROUP_PM);
		end
	end

	// Register number and write data
	always_ff @(posedge clk_i) begin
		if (start) begin
			addr_q <= dbg_adr_i[SPR_REG_W-1:0];
			wdat_q <= dbg_dat_i;
		end
	end

	// Same request fans out to every unit, cs picks the one
	assign spr_pic.cs   = cs_pic_q;
	assign spr_pic.we   = we_q;
	assign spr_pic.addr = addr_q;
	assign spr_pic.wdat = wdat_q;
	assign spr_tt.cs    = cs_tt_q;
	assign spr_tt.we    = we_q;
	assign spr_tt.addr  = addr_q;
	assign spr_tt.wdat  = wdat_q;
	assign spr_pm.cs    = cs_pm_q;
	assign spr_pm.we    = we_q;
	assign spr_pm.addr  = addr_q;
	assign spr_pm.wdat  = wdat_q;

	//////////////////////////////////////////////////////////////////////
	// Response phase
	//////////////////////////////////////////////////////////////////////

	// Read data of the selected unit
	always_comb begin
		rdat_sel = '0;
		if (cs_pic_q) rdat_sel = spr_pic.rdat;
		if (cs_tt_q) rdat_sel = spr_tt.rdat;
		if (cs_pm_q) rdat_sel = spr_pm.rdat;
	end

	// Ack one cycle after the selects, zero data on writes
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			dbg_ack_o <= 1'b0;
			dbg_dat_o <= '0;
		end else begin
			dbg_ack_o <= req_q;
			dbg_dat_o <= (req_q && !we_q) ? rdat_sel : '0;
		end
	end

	// Never two units selected at the same time
	a_cs_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
		$onehot0({spr_pic.cs, spr_tt.cs, spr_pm.cs}));

	// Ack is a single cycle pulse
	a_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
		dbg_ack_o |=> !dbg_ack_o);

endmodule

`default_nettype wire

//--- spr_bus_if.sv
// SPR slave connection with master and slave modports
`timescale 1ns/1ps
`default_nettype none

interface spr_bus_if;
	import or1200_pkg::*;

	// Select, already decoded from the group field
	logic                 cs;
	logic                 we;
	// Register number within the group
	logic [SPR_REG_W-1:0] addr;
	logic [SPR_DW-1:0]    wdat;
	// Combinational read data of the slave
	logic [SPR_DW-1:0]    rdat;

	// Access unit side
	modport master (output cs, output we, output addr, output wdat, input rdat);

	// Register unit side
	modport slave (input cs, input we, input addr, input wdat, output rdat);

endinterface

`default_nettype wire

//--- or1200_pkg.sv
// SPR widths, group numbers, register indices, TTMR and PMR field positions, timer mode type
`default_nettype none

package or1200_pkg;

	//////////////////////////////////////////////////////////////////////
	// SPR bus geometry
	//////////////////////////////////////////////////////////////////////

	// Data and address widths of an SPR access
	localparam int SPR_DW = 32;
	localparam int SPR_AW = 16;

	// Group field sits in the top five address bits
	localparam int SPR_GROUP_MSB = 15;
	localparam int SPR_GROUP_LSB = 11;
	localparam int SPR_GROUP_W   = SPR_GROUP_MSB - SPR_GROUP_LSB + 1;

	// Register number inside a group
	localparam int SPR_REG_W = 11;

	//////////////////////////////////////////////////////////////////////
	// Groups and register numbers
	//////////////////////////////////////////////////////////////////////

	localparam logic [SPR_GROUP_W-1:0] GROUP_PM  = 5'd8;
	localparam logic [SPR_GROUP_W-1:0] GROUP_PIC = 5'd9;
	localparam logic [SPR_GROUP_W-1:0] GROUP_TT  = 5'd10;

	// PIC mask and status
	localparam logic [SPR_REG_W-1:0] PIC_REG_MR = 11'd0;
	localparam logic [SPR_REG_W-1:0] PIC_REG_SR = 11'd2;
	// Tick timer mode and count
	localparam logic [SPR_REG_W-1:0] TT_REG_MR = 11'd0;
	localparam logic [SPR_REG_W-1:0] TT_REG_CR = 11'd1;
	// Power management
	localparam logic [SPR_REG_W-1:0] PM_REG_MR = 11'd0;

	//////////////////////////////////////////////////////////////////////
	// Register fields
	//////////////////////////////////////////////////////////////////////

	// Interrupt lines into the PIC
	localparam int PIC_INTS = 20;

	// TTMR layout
	localparam int TT_TP_W     = 28;
	localparam int TTMR_TP_LSB = 0;
	localparam int TTMR_IP     = 28;
	localparam int TTMR_IE     = 29;
	localparam int TTMR_M_LSB  = 30;
	localparam int TTMR_M_MSB  = 31;

	// Timer modes as coded in TTMR[M]
	typedef enum logic [1:0] {
		TT_DISABLED = 2'b00,
		TT_RESTART  = 2'b01,
		TT_ONESHOT  = 2'b10,
		TT_CONT     = 2'b11
	} tt_mode_t;

	// PMR layout, slowdown factor then doze and sleep enables
	localparam int PM_SDF_W    = 4;
	localparam int PMR_SDF_LSB = 0;
	localparam int PMR_DME     = 4;
	localparam int PMR_SME     = 5;

endpackage

`default_nettype wire
